// ==== compile.f ====
logic/chipBusPkg.sv
logic/byteEnable.sv
logic/cycleSequencer.sv
logic/dataSteering.sv
logic/chipBusBridge.sv
test/chipBusChecker.sv
test/chipBusBridge_assertions.sv
test/chipBusBridgeTb.sv

// ==== test/chipBusBridge_testdata.txt ====
# op(0 rd,1 wr) siz addr tgt(0 ram,1 chip) wdata mdata dmaCycles casUN casLN dbenN
# expLocal expDmaLanes expStrobes expRdata dupStart ; lanes are uu um lm ll active low
0 1 0 0 00000000 11223344 0 1 1 1 7 F 3 11223344 0
1 1 1 0 AABBCCDD 00000000 0 1 1 1 B F 3 00000000 0
0 1 2 0 00000000 55667788 0 1 1 1 D F 3 55667788 0
1 1 3 0 01234567 00000000 0 1 1 1 E F 3 00000000 0
0 2 0 0 00000000 01020304 0 1 1 1 3 F 3 01020304 0
1 2 2 0 76543210 00000000 0 1 1 1 C F 3 00000000 0
0 0 0 0 00000000 DEADBEEF 0 1 1 1 0 F 3 DEADBEEF 0
1 0 0 0 A5A55A5A 00000000 0 1 1 1 0 F 3 00000000 0
0 0 0 0 00000000 CAFEF00D 4 0 0 1 0 3 3 CAFEF00D 0
1 2 2 0 13572468 00000000 3 0 1 0 C D 3 00000000 0
0 1 0 1 00000000 12345678 0 1 1 1 7 F 1 12345678 0
1 1 1 1 9ABC0000 00000000 0 1 1 1 B F 2 00000000 0
0 2 2 1 00000000 11112222 0 1 1 1 C F 0 11112222 0
1 1 3 1 00004321 00000000 0 1 1 1 E F 2 00000000 0
0 0 0 1 00000000 87654321 0 1 1 1 0 F 0 87654321 0
1 0 0 1 0BADF00D 00000000 0 1 1 1 0 F 0 00000000 0
0 1 2 0 00000000 13579BDF 0 1 1 1 D F 3 13579BDF 1
1 2 0 1 FACE0000 00000000 0 1 1 1 3 F 0 00000000 1

// ==== test/chipBusBridgeTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module chipBusBridgeTb;

    import chipBusPkg::*;

    localparam dmaBus_t dmaIdle = 4'b1110;          // CAS high, upper word, no DMA
    localparam int      ramWait = 2;                // Chip-RAM access length in clocks

    logic            clk = 1'b0;
    logic            arstN;
    logic            reqStart;
    cpuReq_t         req;
    dmaBus_t         dmaIn;
    logic [31:0]     ramRdata;
    logic [15:0]     chipRdata;
    logic            chipReady;
    logic            busy, reqAck, ramWrite, chipA1, chipWrite;
    dataWord_t       rdata;
    byteLanes_t      localLanes, ramLanes;
    logic [31:0]     ramWdata;
    chipsetStrobes_t strobes;
    logic [15:0]     chipWdata;

    logic            testActive, testDone;
    logic [31:0]     expRdata;
    byteLanes_t      expLocal, expDma;
    chipsetStrobes_t expStrobes;
    logic [31:0]     modelData;                     // Word both target models return
    integer          seed = 85;
    logic [1:0]      waitLeft;

    always #10 clk = ~clk;

    chipBusBridge #(.ramWaitCycles(ramWait)) uut (
        .clk(clk), .arstN(arstN), .reqStart(reqStart), .req(req), .busy(busy),
        .reqAck(reqAck), .rdata(rdata), .localLanes(localLanes), .dmaIn(dmaIn),
        .ramLanes(ramLanes), .ramWdata(ramWdata), .ramRdata(ramRdata), .ramWrite(ramWrite),
        .strobes(strobes), .chipA1(chipA1), .chipWdata(chipWdata), .chipRdata(chipRdata),
        .chipWrite(chipWrite), .chipReady(chipReady)
    );

    chipBusChecker #(.ramCycles(ramWait)) monitor (
        .clk(clk), .arstN(arstN), .reqInfo(req), .testActive(testActive),
        .testDone(testDone), .expRdata(expRdata), .expLocal(expLocal), .expDma(expDma),
        .expStrobes(expStrobes), .busy(busy), .reqAck(reqAck), .rdata(rdata),
        .localLanes(localLanes), .dmaIn(dmaIn), .ramLanes(ramLanes), .ramWdata(ramWdata),
        .ramWrite(ramWrite), .strobes(strobes), .chipA1(chipA1), .chipWdata(chipWdata),
        .chipWrite(chipWrite), .chipReady(chipReady)
    );

    // Chipset returns the half that chipA1 points at
    assign chipRdata = chipA1 ? modelData[15:0] : modelData[31:16];

    // Chipset ready, 0 to 3 clocks after the strobes show
    always @(posedge clk) begin
        if (chipReady || strobes == 2'b11) begin
            chipReady <= 1'b0;
            waitLeft  <= 2'($unsigned($random(seed)) % 4);
        end else if (waitLeft == 0) begin
            chipReady <= 1'b1;
        end else begin
            waitLeft <= waitLeft - 1'b1;
        end
    end

    initial begin
        integer fd, n, cyc;
        integer op, sz, ad, tg, dn, cu, cl, db, el, ed, es, dp;
        logic [31:0] wd, md, er;
        logic acked;
        string line;

        arstN = 1'b0;
        reqStart = 1'b0;
        req = '0;
        dmaIn = dmaIdle;
        ramRdata = '0;
        modelData = '0;
        chipReady = 1'b0;
        waitLeft = '0;
        testActive = 1'b0;
        testDone = 1'b0;
        expRdata = '0;
        expLocal = 4'hF;
        expDma = 4'hF;
        expStrobes = 2'b11;
        repeat (10) @(posedge clk);
        arstN <= 1'b1;
        repeat (3) @(posedge clk);

        fd = $fopen("test/chipBusBridge_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file");
            $display("CHECKS FAILED");
            $finish;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() < 2 || line[0] == "#") continue;    // Column notes and blanks
            n = $sscanf(line, "%h %h %h %h %h %h %d %h %h %h %h %h %h %h %h",
                        op, sz, ad, tg, wd, md, dn, cu, cl, db, el, ed, es, er, dp);
            if (n != 15) continue;

            @(posedge clk);
            req        <= {ad[1:0], sz[1:0], op[0], tg[0], wd};
            reqStart   <= 1'b1;
            ramRdata   <= md;
            modelData  <= md;
            expRdata   <= er;
            expLocal   <= el[3:0];
            expDma     <= ed[3:0];
            expStrobes <= es[1:0];
            testActive <= 1'b1;
            if (dn > 0) dmaIn <= {cu[0], cl[0], db[0], 1'b1};   // DMA grabs RAM first

            cyc = 0;
            acked = 1'b0;
            while (!acked && cyc < 100) begin
                @(posedge clk);
                if (cyc == dn) dmaIn <= dmaIdle;
                reqStart <= (cyc == 1) && (dp != 0);            // Second start while busy
                @(negedge clk);
                if (reqAck) acked = 1'b1;
                cyc++;
            end
            if (!acked) begin
                $display("timed out waiting for reqAck on data line with address %0d", ad);
                $display("CHECKS FAILED");
                $finish;
            end
            repeat (4) @(posedge clk);                          // Room for a stray reqAck
            reqStart <= 1'b0;
            testDone <= 1'b1;
            @(posedge clk);
            testDone   <= 1'b0;
            testActive <= 1'b0;
        end
        $fclose(fd);
        repeat (2) @(posedge clk);

        $display("tests passed %0d, tests failed %0d, errors %0d, assertion failures %0d",
                 monitor.passCount, monitor.failCount, monitor.errorCount,
                 uut.assertions.failCount);
        if (monitor.failCount == 0 && monitor.errorCount == 0 &&
            uut.assertions.failCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/chipBusBridge_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module chipBusBridgeAssertions (
    input wire logic                        clk,
    input wire logic                        arstN,
    input wire logic                        reqAck,
    input wire logic                        cpuCycle,
    input wire logic                        dmaCycle,
    input wire logic                        dsEnable,
    input wire chipBusPkg::chipsetStrobes_t strobes
);

    int failCount = 0;                      // Failed assertion count

    ackOnePulse: assert property (@(posedge clk) disable iff (!arstN) reqAck |=> !reqAck)
        else begin
            $error("reqAck held longer than one cycle");
            failCount++;
        end

    noCpuDuringDma: assert property (@(posedge clk) disable iff (!arstN) !(cpuCycle && dmaCycle))
        else begin
            $error("cpuCycle high while DMA owns chip RAM");
            failCount++;
        end

    strobesIdle: assert property (@(posedge clk) disable iff (!arstN) !dsEnable |-> strobes == 2'b11)
        else begin
            $error("chipset strobe active without dsEnable");
            failCount++;
        end

endmodule

bind chipBusBridge chipBusBridgeAssertions assertions (
    .clk      (clk),
    .arstN    (arstN),
    .reqAck   (reqAck),
    .cpuCycle (cpuCycle),
    .dmaCycle (dmaIn.dmaCycle),
    .dsEnable (dsEnable),
    .strobes  (strobes)
);

`default_nettype wire

// ==== test/chipBusChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

module chipBusChecker #(
    parameter int ramCycles = 2                                // Clocks per chip-RAM access
) (
    input wire logic                        clk,
    input wire logic                        arstN,
    input wire chipBusPkg::cpuReq_t         reqInfo,       // Request of the running test
    input wire logic                        testActive,
    input wire logic                        testDone,
    input wire logic [31:0]                 expRdata,
    input wire chipBusPkg::byteLanes_t      expLocal,
    input wire chipBusPkg::byteLanes_t      expDma,
    input wire chipBusPkg::chipsetStrobes_t expStrobes,
    input wire logic                        busy,
    input wire logic                        reqAck,
    input wire chipBusPkg::dataWord_t       rdata,
    input wire chipBusPkg::byteLanes_t      localLanes,
    input wire chipBusPkg::dmaBus_t         dmaIn,
    input wire chipBusPkg::byteLanes_t      ramLanes,
    input wire logic [31:0]                 ramWdata,
    input wire logic                        ramWrite,
    input wire chipBusPkg::chipsetStrobes_t strobes,
    input wire logic                        chipA1,
    input wire logic [15:0]                 chipWdata,
    input wire logic                        chipWrite,
    input wire logic                        chipReady
);

    import chipBusPkg::*;

    int   errorCount = 0;
    int   passCount = 0;
    int   failCount = 0;
    int   testNum = 0;
    int   testErrors = 0;
    int   ackCount = 0;
    int   halvesDone = 0;
    int   ramSeen = 0;
    logic resetSeen = 1'b0;
    logic isLong;
    logic expA1;

    task automatic reportMismatch(input string msg);
        $display("mismatch at time %0t: test %0d %s", $time, testNum, msg);
        errorCount++;
        testErrors++;
    endtask

    task automatic closeTest(input string name);
        if (testErrors == 0) begin
            passCount++;
            $display("test %0d %s passed", testNum, name);
        end else begin
            failCount++;
            $display("test %0d %s failed with %0d errors", testNum, name, testErrors);
        end
        testErrors = 0;
        testNum++;
    endtask

    // Sample at the falling edge, away from the DUT's clock edge
    always @(negedge clk) begin
        isLong = (reqInfo.siz == 2'b00) || (reqInfo.siz == 2'b11);
        if (arstN && !resetSeen) begin
            resetSeen = 1'b1;
            if (busy || reqAck) reportMismatch("busy or reqAck high after reset");
            if (localLanes != 4'hF || ramLanes != 4'hF) reportMismatch("lane active after reset");
            if (strobes != 2'b11) reportMismatch("strobe active after reset");
            closeTest("reset state");
        end
        if (testActive) begin
            if (dmaIn.dmaCycle) begin
                if (ramLanes != expDma) reportMismatch($sformatf("DMA lanes %h expected %h",
                    ramLanes, expDma));
                if (reqAck) reportMismatch("reqAck while DMA holds chip RAM");
            end else if (ramLanes != 4'hF) begin
                ramSeen++;
                if (ramLanes != expLocal || localLanes != expLocal)
                    reportMismatch($sformatf("RAM lanes %h local %h expected %h",
                        ramLanes, localLanes, expLocal));
                if (!busy) reportMismatch("busy low during chip RAM cycle");
                if (ramWrite != reqInfo.write) reportMismatch("ramWrite direction wrong");
                if (reqInfo.write && ramWdata != reqInfo.wdata)
                    reportMismatch($sformatf("ramWdata %h expected %h", ramWdata, reqInfo.wdata));
            end
            if (strobes != 2'b11) begin
                if (strobes != expStrobes || localLanes != expLocal)
                    reportMismatch($sformatf("strobes %b local %h expected %b %h",
                        strobes, localLanes, expStrobes, expLocal));
                if (!busy) reportMismatch("busy low during chipset cycle");
                if (chipReady) begin                // Half ends on the coming edge
                    expA1 = isLong ? (halvesDone != 0) : reqInfo.addrLow[1];
                    if (chipA1 != expA1) reportMismatch($sformatf("chipA1 %b expected %b",
                        chipA1, expA1));
                    if (chipWrite != reqInfo.write) reportMismatch("chipWrite direction wrong");
                    if (reqInfo.write && chipWdata != (expA1 ? reqInfo.wdata[15:0]
                                                             : reqInfo.wdata[31:16]))
                        reportMismatch($sformatf("chipWdata %h in wrong half order", chipWdata));
                    halvesDone++;
                end
            end
            if (reqAck) begin
                ackCount++;
                if (busy) reportMismatch("busy still high with reqAck");
                if (!reqInfo.write) begin
                    if (!reqInfo.toChipset || isLong) begin
                        if (rdata.longWord != expRdata)
                            reportMismatch($sformatf("rdata %h expected %h", rdata, expRdata));
                    end else if (reqInfo.addrLow[1] ? rdata.halves.lowerHalf != expRdata[15:0]
                                                    : rdata.halves.upperHalf != expRdata[31:16])
                        reportMismatch($sformatf("rdata half %h expected from %h", rdata,
                            expRdata));
                end
            end
        end
        if (testDone) begin
            if (ackCount != 1) begin
                $display("test %0d expected exactly one reqAck but saw %0d", testNum, ackCount);
                errorCount++;
                testErrors++;
            end
            if (reqInfo.toChipset && halvesDone != (isLong ? 2 : 1)) begin
                $display("test %0d chipset ran %0d halves", testNum, halvesDone);
                errorCount++;
                testErrors++;
            end
            if (!reqInfo.toChipset && ramSeen != ramCycles) begin
                $display("test %0d chip RAM cycle lasted %0d clocks instead of %0d",
                         testNum, ramSeen, ramCycles);
                errorCount++;
                testErrors++;
            end
            closeTest(reqInfo.toChipset ? "chipset" : "chip RAM");
            ackCount = 0;
            halvesDone = 0;
            ramSeen = 0;
        end
    end

endmodule

`default_nettype wire

// ==== logic/chipBusBridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module chipBusBridge #(
    parameter int ramWaitCycles = 2                 // Chip-RAM access length
) (
    input  wire logic                        clk,
    input  wire logic                        arstN,
    // CPU side
    input  wire logic                        reqStart,
    input  wire chipBusPkg::cpuReq_t         req,
    output logic                             busy,
    output logic                             reqAck,
    output chipBusPkg::dataWord_t            rdata,
    output chipBusPkg::byteLanes_t           localLanes,
    // DMA controller
    input  wire chipBusPkg::dmaBus_t         dmaIn,
    // Chip RAM
    output chipBusPkg::byteLanes_t           ramLanes,
    output logic [31:0]                      ramWdata,
    input  wire logic [31:0]                 ramRdata,
    output logic                             ramWrite,
    // Custom chip bus
    output chipBusPkg::chipsetStrobes_t      strobes,
    output logic                             chipA1,
    output logic [15:0]                      chipWdata,
    input  wire logic [15:0]                 chipRdata,
    output logic                             chipWrite,
    input  wire logic                        chipReady
);

    import chipBusPkg::*;

    cpuReq_t latchedReq;                            // Request being served
    logic    cpuCycle;
    logic    dsEnable;
    logic    half;
    logic    captureHalf;

    cycleSequencer #(
        .ramWaitCycles (ramWaitCycles)
    ) sequencer (
        .clk         (clk),
        .arstN       (arstN),
        .reqStart    (reqStart),
        .req         (req),
        .dmaCycle    (dmaIn.dmaCycle),              // Only the ownership bit matters here
        .chipReady   (chipReady),
        .latchedReq  (latchedReq),
        .busy        (busy),
        .reqAck      (reqAck),
        .cpuCycle    (cpuCycle),
        .dsEnable    (dsEnable),
        .half        (half),
        .captureHalf (captureHalf),
        .ramWrite    (ramWrite),
        .chipWrite   (chipWrite)
    );

    byteEnable decoder (
        .addrLow    (latchedReq.addrLow),
        .siz        (latchedReq.siz),
        .cpuCycle   (cpuCycle),
        .dsEnable   (dsEnable),
        .dmaIn      (dmaIn),
        .localLanes (localLanes),
        .ramLanes   (ramLanes),
        .strobes    (strobes)
    );

    dataSteering steering (
        .clk         (clk),
        .arstN       (arstN),
        .wdata       (latchedReq.wdata),            // Same 32 bits seen as a union
        .half        (half),
        .captureHalf (captureHalf),
        .toChipset   (latchedReq.toChipset),
        .ramRdata    (ramRdata),
        .chipRdata   (chipRdata),
        .chipA1      (chipA1),
        .chipWdata   (chipWdata),
        .ramWdata    (ramWdata),
        .rdata       (rdata)
    );

endmodule

`default_nettype wire

// ==== logic/dataSteering.sv ====
`timescale 1ns/1ps
`default_nettype none

module dataSteering (
    input  wire logic                  clk,
    input  wire logic                  arstN,
    input  wire chipBusPkg::dataWord_t wdata,
    input  wire logic                  half,
    input  wire logic                  captureHalf,
    input  wire logic                  toChipset,
    input  wire logic [31:0]           ramRdata,
    input  wire logic [15:0]           chipRdata,
    output logic                       chipA1,
    output logic [15:0]                chipWdata,
    output logic [31:0]                ramWdata,
    output chipBusPkg::dataWord_t      rdata
);

    assign chipA1 = half;                           // Half 1 is the lower word

    // Chipset only sees one 16-bit half at a time
    assign chipWdata = half ? wdata.halves.lowerHalf : wdata.halves.upperHalf;

    // Chip RAM is a full 32-bit path
    assign ramWdata = wdata.longWord;

    // Read register, built up half by half for chipset longwords
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rdata <= '0;
        end else if (captureHalf) begin
            if (!toChipset) begin
                rdata.longWord <= ramRdata;
            end else if (half) begin
                rdata.halves.lowerHalf <= chipRdata;
            end else begin
                rdata.halves.upperHalf <= chipRdata;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/cycleSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module cycleSequencer #(
    parameter int ramWaitCycles = 2         // Clocks per chip-RAM access
) (
    input  wire logic                clk,
    input  wire logic                arstN,
    input  wire logic                reqStart,
    input  wire chipBusPkg::cpuReq_t req,
    input  wire logic                dmaCycle,
    input  wire logic                chipReady,
    output chipBusPkg::cpuReq_t      latchedReq,
    output logic                     busy,
    output logic                     reqAck,
    output logic                     cpuCycle,
    output logic                     dsEnable,
    output logic                     half,
    output logic                     captureHalf,
    output logic                     ramWrite,
    output logic                     chipWrite
);

    import chipBusPkg::*;

    localparam int cntW = (ramWaitCycles > 1) ? $clog2(ramWaitCycles) : 1;
    localparam logic [cntW-1:0] lastCnt = cntW'(ramWaitCycles - 1);

    typedef enum logic [2:0] {
        stIdle,                             // Waiting for a CPU request
        stDmaWait,                          // Chip RAM held by DMA
        stRamAccess,                        // CPU owns chip RAM
        stChipHalf,                         // One chipset half in progress
        stAck                               // Acknowledge to CPU
    } seqState_t;

    seqState_t       state;
    logic [cntW-1:0] waitCnt;               // Clocks spent in stRamAccess
    logic            accept;                // New request taken this clock
    logic            ramLast;               // Final chip-RAM clock
    logic            chipDone;              // Chipset half finishing
    logic            twoHalves;             // Longword split over both halves

    assign busy      = (state == stDmaWait) || (state == stRamAccess) ||
                       (state == stChipHalf);
    assign reqAck    = (state == stAck);
    assign cpuCycle  = (state == stRamAccess);
    assign dsEnable  = (state == stChipHalf);
    assign accept    = reqStart && !busy;           // Back-pressure, busy drops requests

    assign ramLast     = cpuCycle && (waitCnt == lastCnt);
    assign chipDone    = dsEnable && chipReady;
    assign captureHalf = ramLast || chipDone;        // Read data sample point
    assign twoHalves   = isLongword(latchedReq.siz);

    assign ramWrite  = cpuCycle && latchedReq.write;
    assign chipWrite = dsEnable && latchedReq.write;

    // Request payload, held until the next accepted request
    always_ff @(posedge clk) begin
        if (accept) begin
            latchedReq <= req;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state   <= stIdle;
            waitCnt <= '0;
            half    <= 1'b0;
        end else begin
            case (state)
                stIdle, stAck: begin                // Both accept a new request
                    waitCnt <= '0;
                    if (accept) begin
                        if (req.toChipset) begin
                            state <= stChipHalf;
                            // Longword starts on the upper half
                            half  <= isLongword(req.siz) ? 1'b0 : req.addrLow[1];
                        end else if (dmaCycle) begin
                            state <= stDmaWait;     // Keep request until DMA lets go
                        end else begin
                            state <= stRamAccess;
                        end
                    end else begin
                        state <= stIdle;
                    end
                end
                stDmaWait: begin
                    if (!dmaCycle) begin
                        state <= stRamAccess;
                    end
                end
                stRamAccess: begin
                    if (ramLast) begin
                        state <= stAck;
                    end else begin
                        waitCnt <= waitCnt + 1'b1;
                    end
                end
                stChipHalf: begin
                    if (chipReady) begin
                        if (twoHalves && !half) begin
                            half <= 1'b1;           // Move on to the lower half
                        end else begin
                            state <= stAck;
                        end
                    end
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/byteEnable.sv ====
`timescale 1ns/1ps
`default_nettype none

module byteEnable (
    input  wire logic [1:0]                addrLow,
    input  wire chipBusPkg::sizeCode_t     siz,
    input  wire logic                      cpuCycle,
    input  wire logic                      dsEnable,
    input  wire chipBusPkg::dmaBus_t       dmaIn,
    output chipBusPkg::byteLanes_t         localLanes,
    output chipBusPkg::byteLanes_t         ramLanes,
    output chipBusPkg::chipsetStrobes_t    strobes
);

    import chipBusPkg::*;

    logic longTrans;                        // Longword or line
    logic wordTrans;
    logic cpuActive;                        // Any CPU-owned target cycle
    logic uuOn, umOn, lmOn, llOn;           // Active-high lane selects
    logic dmaUpper, dmaLower;               // DMA steered to upper or lower word
    logic udsOn, ldsOn;

    assign longTrans = isLongword(siz);
    assign wordTrans = (siz == sizWord);
    assign cpuActive = cpuCycle || dsEnable;

    // Lane selects for the 32-bit local bus
    assign uuOn = (addrLow == 2'd0);
    assign umOn = (addrLow == 2'd1) || longTrans || (!addrLow[1] && wordTrans);
    assign lmOn = (addrLow == 2'd2) || longTrans;
    assign llOn = (addrLow == 2'd3) || longTrans || (addrLow[1] && wordTrans);

    // Local enables only show while the CPU owns a target
    assign localLanes.uuN = !(uuOn && cpuActive);
    assign localLanes.umN = !(umOn && cpuActive);
    assign localLanes.lmN = !(lmOn && cpuActive);
    assign localLanes.llN = !(llOn && cpuActive);

    assign dmaUpper = dmaIn.dmaCycle && dmaIn.dbenN;
    assign dmaLower = dmaIn.dmaCycle && !dmaIn.dbenN;

    // Chip RAM takes CPU lanes or the DMA CAS pair
    assign ramLanes.uuN = !((uuOn && cpuCycle) || (!dmaIn.casUN && dmaUpper));
    assign ramLanes.umN = !((umOn && cpuCycle) || (!dmaIn.casLN && dmaUpper));
    assign ramLanes.lmN = !((lmOn && cpuCycle) || (!dmaIn.casUN && dmaLower));
    assign ramLanes.llN = !((llOn && cpuCycle) || (!dmaIn.casLN && dmaLower));

    // 16-bit chipset strobes
    assign udsOn = !addrLow[0];                             // Even byte
    assign ldsOn = addrLow[0] || wordTrans || longTrans;    // Odd byte or wider

    assign strobes.udsN = !(dsEnable && udsOn);
    assign strobes.ldsN = !(dsEnable && ldsOn);

endmodule

`default_nettype wire

// ==== logic/chipBusPkg.sv ====
`default_nettype none

package chipBusPkg;

    // 68040 SIZ field encodings
    typedef enum logic [1:0] {
        sizLong = 2'b00,                    // Longword, four bytes
        sizByte = 2'b01,                    // Single byte
        sizWord = 2'b10,                    // Two bytes
        sizLine = 2'b11                     // Burst line, handled as longword
    } sizeCode_t;

    // CPU request as latched by the bridge
    typedef struct packed {
        logic [1:0]  addrLow;               // A1..A0
        sizeCode_t   siz;                   // Transfer size
        logic        write;                 // 1 = CPU writes
        logic        toChipset;             // 1 = custom chip bus, 0 = chip RAM
        logic [31:0] wdata;                 // Write longword
    } cpuReq_t;

    // Active-low byte enables, MSB lane first
    typedef struct packed {
        logic uuN;                          // D31..D24
        logic umN;                          // D23..D16
        logic lmN;                          // D15..D8
        logic llN;                          // D7..D0
    } byteLanes_t;

    typedef struct packed {
        logic [15:0] upperHalf;             // Chipset cycle with A1 low
        logic [15:0] lowerHalf;             // Chipset cycle with A1 high
    } halfPair_t;

    // Data word seen by the CPU as a longword and by the chipset as two halves
    typedef union packed {
        logic [31:0] longWord;
        halfPair_t   halves;
    } dataWord_t;

    // Chip-RAM strobes from the DMA controller
    typedef struct packed {
        logic casUN;                        // Upper CAS, active low
        logic casLN;                        // Lower CAS, active low
        logic dbenN;                        // High steers DMA to upper word
        logic dmaCycle;                     // DMA owns chip RAM
    } dmaBus_t;

    // 68000-style data strobes
    typedef struct packed {
        logic udsN;
        logic ldsN;
    } chipsetStrobes_t;

    // Line bursts are run as plain longwords
    function automatic logic isLongword(input sizeCode_t siz);
        return (siz == sizLong) || (siz == sizLine);
    endfunction

endpackage

`default_nettype wire
